/* Bender.yml */
package:
  name: lz77_scanline

sources:
  - files:
      - hdl/lz77_cfg_pkg.sv
      - hdl/lz77_types_pkg.sv
      - hdl/lz77_buf_if.sv
      - hdl/lz77_ctrl.sv
      - hdl/lz77_buffer.sv
      - hdl/lz77_match.sv
      - hdl/lz77_top.sv
  - target: any(simulation, test)
    files:
      - verif/tb_clk_gen.sv
      - verif/lz77_checker.sv
      - verif/tb_lz77.sv

/* hdl/lz77_buf_if.sv */
// window and lookahead contents passed from the lz77 buffer to the match search
`timescale 1ns/100ps
`default_nettype none

interface lz77_buf_if
  import lz77_cfg_pkg::*;
();

  // sliding window, index 0 is the most recent byte
  logic [WIN_MAX-1:0][BYTE_WD-1:0]  win_dat;
  logic [DST_WD-1:0]                win_len;

  // lookahead, index 0 is the current position
  logic [LOOK_MAX-1:0][BYTE_WD-1:0] look_dat;
  logic [LOOK_WD-1:0]               look_len;

  modport buffer (
    output win_dat,
    output win_len,
    output look_dat,
    output look_len
  );

  modport match (
    input win_dat,
    input win_len,
    input look_dat,
    input look_len
  );

endinterface

`default_nettype wire

/* hdl/lz77_buffer.sv */
// lookahead refill from the filter FIFO and sliding window update of the lz77 compressor
`timescale 1ns/100ps
`default_nettype none

module lz77_buffer
  import lz77_cfg_pkg::*;
(
  input  wire                 clk,
  input  wire                 rstn,
  input  wire                 fetch_i,
  input  wire                 consume_i,
  input  wire  [LEN_WD-1:0]   consume_len_i,
  input  wire  [LINE_WD-1:0]  line_rem_i,
  input  wire                 frame_first_i,
  output logic                fifo_rd_o,
  input  wire  [WORD_WD-1:0]  fifo_dat_i,
  output logic                fill_done_o,
  lz77_buf_if.buffer          buf_bus
);

  logic [LINE_WD-1:0]               rd_rem_r;
  logic                             hdr_r;
  logic                             fill_act_r;
  logic [LINE_WD-1:0]               need;
  logic [LOOK_WD-1:0]               rd_bytes;
  logic [LOOK_MAX-1:0][BYTE_WD-1:0] look_app;
  logic [WIN_MAX-1:0][BYTE_WD-1:0]  win_shift;

  // --------------------------------------------------
  // refill control
  // --------------------------------------------------
  assign need        = (line_rem_i < LINE_WD'(LEN_MAX)) ? line_rem_i : LINE_WD'(LEN_MAX);
  assign fill_done_o = (LINE_WD'(buf_bus.look_len) >= need) || (rd_rem_r == '0);
  assign fifo_rd_o   = fill_act_r && !fill_done_o;
  // first read of a line only delivers the filter type
  assign rd_bytes    = hdr_r ? LOOK_WD'(1) : LOOK_WD'(PXL_BYTES);

  // append fifo bytes behind the valid lookahead, msb first
  always_comb begin
    look_app = buf_bus.look_dat;
    for (int j = 0; j < PXL_BYTES; j++) begin
      if (j < int'(rd_bytes) && int'(buf_bus.look_len) + j < LOOK_MAX) begin
        look_app[int'(buf_bus.look_len) + j] = fifo_dat_i[WORD_WD-1-j*BYTE_WD -: BYTE_WD];
      end
    end
  end

  // consumed bytes enter the window newest first
  always_comb begin
    win_shift = buf_bus.win_dat << (BYTE_WD * consume_len_i);
    for (int i = 0; i < LEN_MAX; i++) begin
      if (i < int'(consume_len_i)) begin
        win_shift[i] = buf_bus.look_dat[int'(consume_len_i) - 1 - i];
      end
    end
  end

  // --------------------------------------------------
  // byte storage
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (fifo_rd_o) begin
      buf_bus.look_dat <= look_app;
    end else if (consume_i) begin
      buf_bus.look_dat <= buf_bus.look_dat >> (BYTE_WD * consume_len_i);
      buf_bus.win_dat  <= win_shift;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_rem_r         <= '0;
      hdr_r            <= 1'b0;
      fill_act_r       <= 1'b0;
      buf_bus.look_len <= '0;
      buf_bus.win_len  <= '0;
    end else begin
      if (fetch_i) begin
        fill_act_r <= 1'b1;
      end else if (fill_done_o) begin
        fill_act_r <= 1'b0;
      end
      // nothing read and nothing pending means a new line
      if (fetch_i && (rd_rem_r == '0) && (buf_bus.look_len == '0)) begin
        rd_rem_r <= line_rem_i;
        hdr_r    <= 1'b1;
      end else if (fifo_rd_o) begin
        rd_rem_r         <= rd_rem_r - LINE_WD'(rd_bytes);
        hdr_r            <= 1'b0;
        buf_bus.look_len <= buf_bus.look_len + rd_bytes;
      end
      if (consume_i) begin
        buf_bus.look_len <= buf_bus.look_len - LOOK_WD'(consume_len_i);
      end
      if (frame_first_i) begin
        buf_bus.win_len <= '0;
      end else if (consume_i) begin
        if (buf_bus.win_len + DST_WD'(consume_len_i) >= DST_WD'(WIN_MAX)) begin
          buf_bus.win_len <= DST_WD'(WIN_MAX);
        end else begin
          buf_bus.win_len <= buf_bus.win_len + DST_WD'(consume_len_i);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/lz77_cfg_pkg.sv */
// sizing constants of the lz77 compressor, imported by every RTL block that needs a width
`default_nettype none

package lz77_cfg_pkg;

  // --------------------------------------------------
  // data sizes
  // --------------------------------------------------
  localparam int BYTE_WD   = 8;
  localparam int PXL_BYTES = 4;
  localparam int WORD_WD   = BYTE_WD * PXL_BYTES;

  // --------------------------------------------------
  // match limits
  // --------------------------------------------------
  localparam int LEN_MIN  = 3;
  localparam int LEN_MAX  = 8;
  localparam int WIN_MAX  = 16;
  // a refill appends one whole word to fewer than LEN_MAX bytes
  localparam int LOOK_MAX = LEN_MAX + PXL_BYTES - 1;

  // line size configuration
  localparam int W_WD = 6;
  localparam int H_WD = 6;

  // derived widths
  localparam int LEN_WD    = $clog2(LEN_MAX + 1);
  localparam int DST_WD    = $clog2(WIN_MAX + 1);
  localparam int LOOK_WD   = $clog2(LOOK_MAX + 1);
  localparam int LINE_WD   = $clog2(PXL_BYTES * (2**W_WD - 1) + 2);
  localparam int SEARCH_WD = $clog2(LEN_MAX + 1);

endpackage

`default_nettype wire

/* hdl/lz77_ctrl.sv */
// line and frame sequencing of the lz77 compressor, drives refill, search and token output
`timescale 1ns/100ps
`default_nettype none

module lz77_ctrl
  import lz77_cfg_pkg::*;
  import lz77_types_pkg::*;
(
  input  wire                clk,
  input  wire                rstn,
  input  wire                start_i,
  input  wire  [W_WD-1:0]    cfg_w_i,
  input  wire  [H_WD-1:0]    cfg_h_i,
  input  wire                fill_done_i,
  input  wire                tok_done_i,
  input  wire  token_t       tok_i,
  output logic               fetch_o,
  output logic               search_o,
  output logic               consume_o,
  output logic [LINE_WD-1:0] line_rem_o,
  output logic               frame_first_o,
  output logic               val_o,
  output token_t             tok_o,
  output logic               done_o,
  output logic               last_o
);

  ctrl_state_e        state_r;
  ctrl_state_e        state_n;
  logic [H_WD-1:0]    line_cnt_r;
  logic [H_WD-1:0]    h_r;
  logic               last_pend_r;
  logic [LINE_WD-1:0] rem_n;
  logic               is_last;
  logic               line_end;
  token_t             tok_r;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------
  assign rem_n         = line_rem_o - LINE_WD'(tok_i.len);
  assign is_last       = (line_cnt_r == h_r - H_WD'(1));
  assign search_o      = (state_r == SEARCH);
  assign consume_o     = (state_r == SEARCH) && tok_done_i;
  assign frame_first_o = (state_r == IDLE) && start_i && (line_cnt_r == '0);
  // last token of the line left the output register
  assign line_end      = val_o && (line_rem_o == '0);

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_comb begin
    state_n = state_r;
    case (state_r)
      IDLE: begin
        if (start_i) state_n = FETCH;
      end
      // fill_done is stale in the cycle of the fetch pulse
      FETCH: begin
        if (fill_done_i && !fetch_o) state_n = SEARCH;
      end
      SEARCH: begin
        if (tok_done_i) state_n = (rem_n == '0) ? IDLE : FETCH;
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r     <= IDLE;
      fetch_o     <= 1'b0;
      val_o       <= 1'b0;
      done_o      <= 1'b0;
      last_o      <= 1'b0;
      line_rem_o  <= '0;
      line_cnt_r  <= '0;
      h_r         <= '0;
      last_pend_r <= 1'b0;
    end else begin
      state_r <= state_n;
      fetch_o <= (state_n == FETCH) && (state_r != FETCH);
      val_o   <= consume_o;
      done_o  <= line_end;
      last_o  <= line_end && last_pend_r;
      if ((state_r == IDLE) && start_i) begin
        // filter byte plus four bytes per pixel
        line_rem_o <= LINE_WD'(PXL_BYTES) * LINE_WD'(cfg_w_i) + LINE_WD'(1);
        h_r        <= cfg_h_i;
      end else if (consume_o) begin
        line_rem_o <= rem_n;
        if (rem_n == '0) begin
          last_pend_r <= is_last;
          line_cnt_r  <= is_last ? '0 : line_cnt_r + H_WD'(1);
        end
      end
    end
  end

  // --------------------------------------------------
  // token output
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (consume_o) begin
      tok_r <= tok_i;
    end
  end

  assign tok_o = val_o ? tok_r : '0;

endmodule

`default_nettype wire

/* hdl/lz77_match.sv */
// greedy match search of the lz77 compressor, tests one length per cycle over all distances
`timescale 1ns/100ps
`default_nettype none

module lz77_match
  import lz77_cfg_pkg::*;
  import lz77_types_pkg::*;
(
  input  wire                clk,
  input  wire                rstn,
  input  wire                search_i,
  input  wire  [LINE_WD-1:0] line_rem_i,
  output logic               tok_done_o,
  output token_t             tok_o,
  lz77_buf_if.match          buf_bus
);

  logic [SEARCH_WD-1:0]                     k_r;
  logic [WIN_MAX-1:0]                       cand_r;
  logic [WIN_MAX-1:0]                       cand_cur;
  logic [WIN_MAX-1:0]                       cand_n;
  logic [WIN_MAX-1:0]                       init_mask;
  logic [WIN_MAX-1:0]                       eq;
  logic [LEN_WD-1:0]                        best_len_r;
  logic [LEN_WD-1:0]                        len_n;
  logic [DST_WD-1:0]                        best_dst_r;
  logic [DST_WD-1:0]                        dst_n;
  logic [WIN_MAX+LOOK_MAX-1:0][BYTE_WD-1:0] seq;
  logic [LINE_WD-1:0]                       lim;
  logic [LINE_WD-1:0]                       len_try;
  logic                                     active;
  logic                                     stop;
  token_t                                   tok_n;

  // priority pick, smallest surviving distance
  function automatic logic [DST_WD-1:0] first_dist(input logic [WIN_MAX-1:0] flags);
    logic [DST_WD-1:0] d;
    d = '0;
    for (int i = WIN_MAX - 1; i >= 0; i--) begin
      if (flags[i]) d = DST_WD'(i + 1);
    end
    return d;
  endfunction

  // --------------------------------------------------
  // candidate update
  // --------------------------------------------------
  // hold off while the previous token is handed over
  assign active  = search_i && !tok_done_o;
  assign len_try = LINE_WD'(k_r) + LINE_WD'(1);

  always_comb begin
    lim = LINE_WD'(LEN_MAX);
    if (line_rem_i < lim) lim = line_rem_i;
    if (LINE_WD'(buf_bus.look_len) < lim) lim = LINE_WD'(buf_bus.look_len);
  end

  // oldest window byte first, then the lookahead, so runs may overlap
  always_comb begin
    for (int i = 0; i < WIN_MAX; i++) begin
      seq[i]       = buf_bus.win_dat[WIN_MAX - 1 - i];
      init_mask[i] = (i < int'(buf_bus.win_len));
    end
    for (int j = 0; j < LOOK_MAX; j++) begin
      seq[WIN_MAX + j] = buf_bus.look_dat[j];
    end
    // bit i stands for distance i+1
    for (int i = 0; i < WIN_MAX; i++) begin
      eq[i] = (seq[WIN_MAX + int'(k_r) - 1 - i] == buf_bus.look_dat[k_r]);
    end
  end

  assign cand_cur = (k_r == '0) ? init_mask : cand_r;
  assign cand_n   = cand_cur & eq;
  assign stop     = (cand_n == '0) || (len_try >= lim);

  // --------------------------------------------------
  // token build
  // --------------------------------------------------
  always_comb begin
    if (cand_n != '0) begin
      len_n = LEN_WD'(len_try);
      dst_n = first_dist(cand_n);
    end else if (k_r == '0) begin
      len_n = '0;
      dst_n = '0;
    end else begin
      len_n = best_len_r;
      dst_n = best_dst_r;
    end
    tok_n = '0;
    if (len_n < LEN_WD'(LEN_MIN)) begin
      tok_n.lit     = 1'b1;
      tok_n.lit_dat = buf_bus.look_dat[0];
      tok_n.len     = LEN_WD'(1);
    end else begin
      tok_n.len = len_n;
      tok_n.dst = dst_n;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      k_r        <= '0;
      cand_r     <= '0;
      best_len_r <= '0;
      best_dst_r <= '0;
      tok_done_o <= 1'b0;
    end else begin
      tok_done_o <= active && stop;
      if (active) begin
        cand_r     <= cand_n;
        best_len_r <= len_n;
        best_dst_r <= dst_n;
        k_r        <= stop ? '0 : k_r + SEARCH_WD'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active && stop) begin
      tok_o <= tok_n;
    end
  end

endmodule

`default_nettype wire

/* hdl/lz77_top.sv */
// top level of the lz77 scanline compressor, connects controller, buffer and matcher to pins
`timescale 1ns/100ps
`default_nettype none

module lz77_top
  import lz77_cfg_pkg::*;
  import lz77_types_pkg::*;
(
  input  wire                clk,
  input  wire                rstn,
  input  wire                start_i,
  input  wire  [W_WD-1:0]    cfg_w_i,
  input  wire  [H_WD-1:0]    cfg_h_i,
  output logic               fifo_rd_o,
  input  wire  [WORD_WD-1:0] fifo_dat_i,
  output logic               val_o,
  output logic               lit_o,
  output logic [BYTE_WD-1:0] lit_dat_o,
  output logic [LEN_WD-1:0]  len_o,
  output logic [DST_WD-1:0]  dst_o,
  output logic               done_o,
  output logic               last_o
);

  logic               fetch;
  logic               search;
  logic               consume;
  logic               frame_first;
  logic               fill_done;
  logic               tok_done;
  logic [LINE_WD-1:0] line_rem;
  token_t             match_tok;
  token_t             out_tok;

  lz77_buf_if buf_bus ();

  // --------------------------------------------------
  // blocks
  // --------------------------------------------------
  lz77_ctrl u_ctrl (
    .clk           (clk),
    .rstn          (rstn),
    .start_i       (start_i),
    .cfg_w_i       (cfg_w_i),
    .cfg_h_i       (cfg_h_i),
    .fill_done_i   (fill_done),
    .tok_done_i    (tok_done),
    .tok_i         (match_tok),
    .fetch_o       (fetch),
    .search_o      (search),
    .consume_o     (consume),
    .line_rem_o    (line_rem),
    .frame_first_o (frame_first),
    .val_o         (val_o),
    .tok_o         (out_tok),
    .done_o        (done_o),
    .last_o        (last_o)
  );

  // consume length comes straight from the matcher token
  lz77_buffer u_buffer (
    .clk           (clk),
    .rstn          (rstn),
    .fetch_i       (fetch),
    .consume_i     (consume),
    .consume_len_i (match_tok.len),
    .line_rem_i    (line_rem),
    .frame_first_i (frame_first),
    .fifo_rd_o     (fifo_rd_o),
    .fifo_dat_i    (fifo_dat_i),
    .fill_done_o   (fill_done),
    .buf_bus       (buf_bus.buffer)
  );

  lz77_match u_match (
    .clk        (clk),
    .rstn       (rstn),
    .search_i   (search),
    .line_rem_i (line_rem),
    .tok_done_o (tok_done),
    .tok_o      (match_tok),
    .buf_bus    (buf_bus.match)
  );

  // token fields onto the output pins
  assign lit_o     = out_tok.lit;
  assign lit_dat_o = out_tok.lit_dat;
  assign len_o     = out_tok.len;
  assign dst_o     = out_tok.dst;

endmodule

`default_nettype wire

/* hdl/lz77_types_pkg.sv */
// controller state and token types shared by the lz77 controller, matcher and top level
`default_nettype none

package lz77_types_pkg;

  import lz77_cfg_pkg::*;

  // --------------------------------------------------
  // controller states
  // --------------------------------------------------
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    SEARCH
  } ctrl_state_e;

  // --------------------------------------------------
  // one output token
  // --------------------------------------------------
  // a literal carries len 1 so it can drive the consume length directly
  typedef struct packed {
    logic               lit;
    logic [BYTE_WD-1:0] lit_dat;
    logic [LEN_WD-1:0]  len;
    logic [DST_WD-1:0]  dst;
  } token_t;

endpackage

`default_nettype wire

/* src.f */
hdl/lz77_cfg_pkg.sv
hdl/lz77_types_pkg.sv
hdl/lz77_buf_if.sv
hdl/lz77_ctrl.sv
hdl/lz77_buffer.sv
hdl/lz77_match.sv
hdl/lz77_top.sv
verif/tb_clk_gen.sv
verif/lz77_checker.sv
verif/tb_lz77.sv

/* verif/lz77_checker.sv */
// protocol assertions on the lz77 top level, bound into every lz77_top instance
`timescale 1ns/100ps
`default_nettype none

module lz77_checker
  import lz77_cfg_pkg::*;
(
  input wire               clk,
  input wire               rstn,
  input wire               start_i,
  input wire               fifo_rd_o,
  input wire               val_o,
  input wire               lit_o,
  input wire [BYTE_WD-1:0] lit_dat_o,
  input wire [LEN_WD-1:0]  len_o,
  input wire [DST_WD-1:0]  dst_o,
  input wire               done_o
);

  // failed assertion count
  int unsigned fail_cnt = 0;
  logic        idle_r;

  // high from done_o until the next start_i
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      idle_r <= 1'b1;
    end else if (start_i) begin
      idle_r <= 1'b0;
    end else if (done_o) begin
      idle_r <= 1'b1;
    end
  end

  // --------------------------------------------------
  // assertions
  // --------------------------------------------------
  a_val_done_apart: assert property (
    @(posedge clk) disable iff (!rstn) !(val_o && done_o)
  ) else begin
    $error("val_o and done_o pulsed in the same cycle");
    fail_cnt++;
  end

  a_match_len: assert property (
    @(posedge clk) disable iff (!rstn)
    (val_o && !lit_o) |-> (len_o >= LEN_MIN && len_o <= LEN_MAX)
  ) else begin
    $error("match length out of range");
    fail_cnt++;
  end

  a_match_dst: assert property (
    @(posedge clk) disable iff (!rstn)
    (val_o && !lit_o) |-> (dst_o >= 1 && dst_o <= WIN_MAX)
  ) else begin
    $error("match distance out of range");
    fail_cnt++;
  end

  a_idle_quiet: assert property (
    @(posedge clk) disable iff (!rstn)
    !val_o |-> (!lit_o && lit_dat_o == '0 && len_o == '0 && dst_o == '0)
  ) else begin
    $error("token outputs not zero while val_o is low");
    fail_cnt++;
  end

  a_no_read_idle: assert property (
    @(posedge clk) disable iff (!rstn) idle_r |-> !fifo_rd_o
  ) else begin
    $error("fifo read between done_o and the next start_i");
    fail_cnt++;
  end

endmodule

bind lz77_top lz77_checker u_checker (
  .clk       (clk),
  .rstn      (rstn),
  .start_i   (start_i),
  .fifo_rd_o (fifo_rd_o),
  .val_o     (val_o),
  .lit_o     (lit_o),
  .lit_dat_o (lit_dat_o),
  .len_o     (len_o),
  .dst_o     (dst_o),
  .done_o    (done_o)
);

`default_nettype wire

/* verif/tb_clk_gen.sv */
// clock and reset source of the lz77 testbench, 100 ns clock with reset low for 4 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rstn_o
);

  localparam int HALF_NS    = 50;
  localparam int RST_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  // release away from the active edge
  initial begin
    rstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rstn_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* verif/tb_lz77.sv */
// testbench of the lz77 compressor that checks random and constant frames against a greedy model
`timescale 1ns/100ps
`default_nettype none

module tb_lz77
  import lz77_cfg_pkg::*;
  import lz77_types_pkg::*;
();

  localparam int N_FRAMES     = 6;
  localparam int FLAT_FRAME   = 2;
  localparam int MEM_WORDS    = 1024;
  localparam int RST_TIMEOUT  = 20;
  localparam int LINE_TIMEOUT = 2000;

  wire                clk;
  wire                rstn;
  logic               start;
  logic [W_WD-1:0]    cfg_w;
  logic [H_WD-1:0]    cfg_h;
  logic               fifo_rd;
  logic [WORD_WD-1:0] fifo_dat;
  logic               val;
  logic               lit;
  logic [BYTE_WD-1:0] lit_dat;
  logic [LEN_WD-1:0]  len;
  logic [DST_WD-1:0]  dst;
  logic               done;
  logic               last;

  logic [WORD_WD-1:0] word_mem [MEM_WORDS];
  logic [BYTE_WD-1:0] frame_q[$];
  token_t             exp_q[$];
  int                 line_tok_q[$];
  int                 frm_w [N_FRAMES];
  int                 frm_h [N_FRAMES];
  logic [31:0]        lfsr_q = 32'd32;
  int                 wr_ptr = 0;
  int                 rd_ptr = 0;
  int                 err_cnt = 0;
  int                 rd_cnt = 0;
  int                 tok_cnt = 0;
  int                 line_tok_exp = 0;
  int                 cur_w = 0;
  bit                 cur_last = 1'b0;
  bit                 line_open = 1'b0;
  bit                 first_tok = 1'b0;
  bit                 done_due = 1'b0;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  lz77_top uut (
    .clk        (clk),
    .rstn       (rstn),
    .start_i    (start),
    .cfg_w_i    (cfg_w),
    .cfg_h_i    (cfg_h),
    .fifo_rd_o  (fifo_rd),
    .fifo_dat_i (fifo_dat),
    .val_o      (val),
    .lit_o      (lit),
    .lit_dat_o  (lit_dat),
    .len_o      (len),
    .dst_o      (dst),
    .done_o     (done),
    .last_o     (last)
  );

  // --------------------------------------------------
  // reporting and compare tasks
  // --------------------------------------------------
  task automatic finish_run();
    if (err_cnt == 0 && uut.u_checker.fail_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "simulation stopped at the first error");
    end
  endtask

  task automatic raise_error(input string msg);
    $display("%s", msg);
    err_cnt++;
    finish_run();
  endtask

  function automatic string token_text(input token_t t);
    return $sformatf("lit=%0b byte=%02h len=%0d dst=%0d", t.lit, t.lit_dat, t.len, t.dst);
  endfunction

  task automatic check_token(input token_t got, input token_t exp, input string what);
    if (got !== exp) begin
      raise_error($sformatf("Mismatch at %0t: %s got %s, expected %s",
                            $time, what, token_text(got), token_text(exp)));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      raise_error($sformatf("Mismatch at %0t: %s, got %0b expected %0b", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      raise_error($sformatf("Mismatch at %0t: %s, got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  // --------------------------------------------------
  // random bytes
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  // small alphabet so that repeats are common
  function automatic logic [BYTE_WD-1:0] pick_byte(input int sel);
    case (sel)
      0:       return 8'h00;
      1:       return 8'h3c;
      2:       return 8'h80;
      default: return 8'hff;
    endcase
  endfunction

  // --------------------------------------------------
  // greedy reference model
  // --------------------------------------------------
  task automatic model_line(input int base);
    token_t t;
    int     p;
    int     e;
    int     win;
    int     l;
    int     best_len;
    int     best_dst;
    int     n_tok;
    p     = base;
    e     = frame_q.size();
    n_tok = 0;
    while (p < e) begin
      best_len = 0;
      best_dst = 0;
      win      = (p < WIN_MAX) ? p : WIN_MAX;
      // ascending distance keeps the nearest on a tie
      for (int d = 1; d <= win; d++) begin
        l = 0;
        while (l < LEN_MAX && p + l < e && frame_q[p + l] == frame_q[p + l - d]) begin
          l++;
        end
        if (l > best_len) begin
          best_len = l;
          best_dst = d;
        end
      end
      t = '0;
      if (best_len < LEN_MIN) begin
        t.lit     = 1'b1;
        t.lit_dat = frame_q[p];
        t.len     = LEN_WD'(1);
        p++;
      end else begin
        t.len = LEN_WD'(best_len);
        t.dst = DST_WD'(best_dst);
        p += best_len;
      end
      exp_q.push_back(t);
      n_tok++;
    end
    line_tok_q.push_back(n_tok);
  endtask

  // fifo words and expected tokens of one frame
  task automatic build_frame(input int w, input int h, input bit flat);
    logic [BYTE_WD-1:0] b;
    logic [WORD_WD-1:0] word;
    int                 base;
    frame_q.delete();
    for (int l = 0; l < h; l++) begin
      base = frame_q.size();
      b    = flat ? 8'h55 : BYTE_WD'(take_bits(2));
      frame_q.push_back(b);
      // filter type in the top byte and filler below it
      word_mem[wr_ptr] = {b, 24'(~wr_ptr)};
      wr_ptr++;
      for (int p = 0; p < w; p++) begin
        for (int j = 0; j < PXL_BYTES; j++) begin
          b = flat ? 8'h55 : pick_byte(take_bits(2));
          frame_q.push_back(b);
          word[WORD_WD-1-j*BYTE_WD -: BYTE_WD] = b;
        end
        word_mem[wr_ptr] = word;
        wr_ptr++;
      end
      model_line(base);
    end
  endtask

  // --------------------------------------------------
  // show-ahead fifo
  // --------------------------------------------------
  always @(posedge clk) begin
    if (fifo_rd) begin
      rd_ptr   <= rd_ptr + 1;
      fifo_dat <= word_mem[rd_ptr + 1];
    end else begin
      fifo_dat <= word_mem[rd_ptr];
    end
  end

  // --------------------------------------------------
  // output monitor
  // --------------------------------------------------
  always @(negedge clk) begin : monitor
    token_t got;
    token_t exp;
    if (rstn) begin
      if (uut.u_checker.fail_cnt != 0) begin
        raise_error("a protocol assertion failed in the bound checker");
      end
      check_flag(done, done_due, "done_o one cycle after the last token of a line");
      check_flag(last, done_due && cur_last, "last_o with done_o of the final line only");
      if (done) begin
        check_count(rd_cnt, cur_w + 1, "fifo reads in the line");
        line_open = 1'b0;
        rd_cnt    = 0;
        tok_cnt   = 0;
      end
      done_due = 1'b0;
      if (fifo_rd) begin
        rd_cnt++;
      end
      if (val) begin
        if (!line_open || exp_q.size() == 0) begin
          raise_error("token on val_o while no line was expected to produce one");
        end
        got.lit     = lit;
        got.lit_dat = lit_dat;
        got.len     = len;
        got.dst     = dst;
        exp         = exp_q.pop_front();
        // window is empty at frame start
        if (first_tok) begin
          check_flag(lit, 1'b1, "first token of a frame is a literal");
        end
        first_tok = 1'b0;
        check_token(got, exp, "token");
        tok_cnt++;
        done_due = (tok_cnt == line_tok_exp);
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic wait_reset();
    int n;
    n = 0;
    while (!rstn) begin
      if (n == RST_TIMEOUT) begin
        raise_error("timeout waiting for reset release");
      end
      @(posedge clk);
      n++;
    end
  endtask

  task automatic run_line(input int w, input int h, input int l);
    int n;
    @(posedge clk);
    start        <= 1'b1;
    cfg_w        <= W_WD'(w);
    cfg_h        <= H_WD'(h);
    cur_w        = w;
    cur_last     = (l == h - 1);
    line_tok_exp = line_tok_q.pop_front();
    first_tok    = (l == 0);
    line_open    = 1'b1;
    @(posedge clk);
    start <= 1'b0;
    n = 0;
    while (line_open) begin
      if (n == LINE_TIMEOUT) begin
        raise_error("timeout waiting for done_o at the end of a line");
      end
      @(posedge clk);
      n++;
    end
  endtask

  initial begin : stimulus
    bit flat;
    start    = 1'b0;
    cfg_w    = '0;
    cfg_h    = '0;
    fifo_dat = '0;
    // one constant frame among the random ones
    for (int f = 0; f < N_FRAMES; f++) begin
      flat     = (f == FLAT_FRAME);
      frm_w[f] = flat ? 6 : take_bits(3) + 1;
      frm_h[f] = flat ? 3 : take_bits(2) + 1;
      build_frame(frm_w[f], frm_h[f], flat);
    end
    wait_reset();
    for (int f = 0; f < N_FRAMES; f++) begin
      for (int l = 0; l < frm_h[f]; l++) begin
        run_line(frm_w[f], frm_h[f], l);
      end
    end
    repeat (4) @(posedge clk);
    finish_run();
  end

endmodule

`default_nettype wire
